//--- verilog/cpuPkg.sv
`default_nettype none

package cpuPkg;

	typedef logic [15:0] word;
	typedef logic [1:0] regIndex; // 0 ax, 1 bx, 2 cx, 3 dx
	typedef logic [3:0] aluOp;

	localparam word opNop = 16'h0000;
	localparam word opScf = 16'h0001;
	localparam word opCff = 16'h0002;
	localparam word opCof = 16'h0003;
	localparam word opCzf = 16'h0004;
	localparam word opMov3 = 16'h0007; // reg <- reg
	localparam word opMov4 = 16'h0008; // reg <- immediate
	localparam word opPop = 16'h0009;
	localparam word opOut = 16'h000A;
	localparam word opPush = 16'h000B;
	localparam word opAdd = 16'h000C;
	localparam word opAdc = 16'h000D;
	localparam word opSub = 16'h000E;
	localparam word opSuc = 16'h000F;
	localparam word opCmp = 16'h0014;
	localparam word opAnd = 16'h0015;
	localparam word opNeg = 16'h0016;
	localparam word opNot = 16'h0017;
	localparam word opOr = 16'h0018;
	localparam word opShl = 16'h0019;
	localparam word opShr = 16'h001A;
	localparam word opXor = 16'h001B;
	localparam word opTest = 16'h001C;
	localparam word opCall = 16'h001E;
	localparam word opRet = 16'h001F;
	localparam word opJmp1 = 16'h0020; // bp relative
	localparam word opJc = 16'h0021;
	localparam word opJnc = 16'h0022;
	localparam word opJz = 16'h0023;
	localparam word opJnz = 16'h0024;
	localparam word opJo = 16'h0025;
	localparam word opJno = 16'h0026;
	localparam word opMov5 = 16'h002A; // mem <- reg, absolute
	localparam word opMov6 = 16'h002B; // reg <- mem, absolute
	localparam word opJmp2 = 16'h0031; // absolute

	localparam aluOp aluAdd = 4'h0;
	localparam aluOp aluAdc = 4'h1;
	localparam aluOp aluSub = 4'h2;
	localparam aluOp aluSuc = 4'h3;
	localparam aluOp aluAnd = 4'h4;
	localparam aluOp aluOr = 4'h5;
	localparam aluOp aluXor = 4'h6;
	localparam aluOp aluNeg = 4'h7;
	localparam aluOp aluNot = 4'h8;
	localparam aluOp aluShl = 4'h9;
	localparam aluOp aluShr = 4'hA;

	typedef enum logic {
		stExec,
		stAluWait // collect the registered sum and flags
	} execState;

endpackage

`default_nettype wire

//--- verilog/programMemory.sv
`timescale 1ns/1ns
`default_nettype none

module programMemory #(
	parameter int memAddrWidth = 11
) (
	input logic clk,
	input logic loadEn,
	input cpuPkg::word loadAddr,
	input cpuPkg::word loadData,
	input cpuPkg::word fetchAddr,
	output cpuPkg::word opcode,
	output cpuPkg::word par1,
	output cpuPkg::word par2,
	input cpuPkg::word dataAddr,
	input logic dataWrite,
	input cpuPkg::word dataIn,
	output cpuPkg::word dataOut
);

	cpuPkg::word mem [2**memAddrWidth];
	logic [memAddrWidth-1:0] fetchBase;

	assign fetchBase = fetchAddr[memAddrWidth-1:0];
	assign opcode = mem[fetchBase];
	assign par1 = mem[fetchBase + memAddrWidth'(1)]; // window wraps at the top
	assign par2 = mem[fetchBase + memAddrWidth'(2)];
	assign dataOut = mem[dataAddr[memAddrWidth-1:0]];

	always_ff @(posedge clk) begin
		if (loadEn) begin
			mem[loadAddr[memAddrWidth-1:0]] <= loadData;
		end else if (dataWrite) begin
			mem[dataAddr[memAddrWidth-1:0]] <= dataIn; // MOV5
		end
	end

	// loading only happens while the core is held with run low
	loadDataClash: assert property (@(posedge clk) !(loadEn && dataWrite))
		else $error("load port and data port write in the same cycle");

endmodule

`default_nettype wire

//--- verilog/registerFile.sv
`timescale 1ns/1ns
`default_nettype none

module registerFile (
	input logic clk,
	input logic reset,
	input cpuPkg::regIndex readSelA,
	input cpuPkg::regIndex readSelB,
	output cpuPkg::word readA,
	output cpuPkg::word readB,
	input logic writeEnA,
	input cpuPkg::regIndex writeSelA,
	input cpuPkg::word writeDataA,
	input logic writeEnB,
	input cpuPkg::regIndex writeSelB,
	input cpuPkg::word writeDataB,
	output cpuPkg::word bx,
	output cpuPkg::word dx
);

	cpuPkg::word regs [4]; // ax, bx, cx, dx

	assign readA = regs[readSelA];
	assign readB = regs[readSelB];
	assign bx = regs[1]; // OUT address
	assign dx = regs[3]; // OUT data

	always_ff @(posedge clk) begin
		if (!reset) begin
			for (int i = 0; i < 4; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (writeEnB) begin
				regs[writeSelB] <= writeDataB; // POP, MOV6, flag copies
			end
			if (writeEnA) begin
				regs[writeSelA] <= writeDataA; // last write wins, so A has priority
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
	input logic clk,
	input logic reset,
	input cpuPkg::aluOp op,
	input cpuPkg::word a,
	input cpuPkg::word b,
	input logic carryIn,
	input logic aluStart,
	output cpuPkg::word logicResult,
	output cpuPkg::word arithResult,
	output logic carry,
	output logic zero,
	output logic overflow
);

	logic [16:0] sum; // bit 16 is carry or borrow
	logic isSub;
	logic sumOverflow;

	always_comb begin
		case (op)
			cpuPkg::aluAnd: logicResult = a & b;
			cpuPkg::aluOr: logicResult = a | b;
			cpuPkg::aluXor: logicResult = a ^ b;
			cpuPkg::aluNeg: logicResult = ~a;
			cpuPkg::aluNot: logicResult = cpuPkg::word'(a == '0); // 1 only for zero
			cpuPkg::aluShl: logicResult = a << 1;
			cpuPkg::aluShr: logicResult = a >> 1;
			default: logicResult = a;
		endcase
	end

	assign isSub = (op == cpuPkg::aluSub) || (op == cpuPkg::aluSuc);

	always_comb begin
		case (op)
			cpuPkg::aluAdc: sum = {1'b0, a} + {1'b0, b} + {16'b0, carryIn};
			cpuPkg::aluSub: sum = {1'b0, a} - {1'b0, b};
			cpuPkg::aluSuc: sum = {1'b0, a} - {1'b0, b} - {16'b0, carryIn};
			default: sum = {1'b0, a} + {1'b0, b};
		endcase
	end

	// signed overflow: operand signs vs result sign
	assign sumOverflow = isSub ? ((a[15] != b[15]) && (sum[15] != a[15]))
		: ((a[15] == b[15]) && (sum[15] != a[15]));

	always_ff @(posedge clk) begin
		if (aluStart) begin
			arithResult <= sum[15:0];
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			carry <= 1'b0;
			zero <= 1'b0;
			overflow <= 1'b0;
		end else if (aluStart) begin
			carry <= sum[16];
			zero <= (sum[15:0] == '0);
			overflow <= sumOverflow;
		end
	end

endmodule

`default_nettype wire

//--- verilog/callStack.sv
`timescale 1ns/1ns
`default_nettype none

module callStack #(
	parameter int stackDepth = 64
) (
	input logic clk,
	input logic reset,
	input logic push,
	input logic pop,
	input logic pair,
	input cpuPkg::word pushLow,
	input cpuPkg::word pushHigh,
	output cpuPkg::word topWord,
	output cpuPkg::word nextWord
);

	localparam int idxWidth = $clog2(stackDepth);

	cpuPkg::word stack [stackDepth];
	logic [idxWidth:0] sp; // next free slot
	logic [idxWidth:0] step;
	logic [idxWidth-1:0] spIdx;

	assign spIdx = sp[idxWidth-1:0];
	assign step = {{(idxWidth-1){1'b0}}, pair, ~pair}; // 2 for CALL/RET, else 1
	assign topWord = stack[spIdx - idxWidth'(1)];
	assign nextWord = stack[spIdx - idxWidth'(2)];

	always_ff @(posedge clk) begin
		if (push) begin
			stack[spIdx] <= pushLow;
			if (pair) begin
				stack[spIdx + idxWidth'(1)] <= pushHigh; // return address on top
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			sp <= '0;
		end else if (push) begin
			sp <= sp + step;
		end else if (pop) begin
			sp <= sp - step;
		end
	end

	stackOverflow: assert property (@(posedge clk) disable iff (!reset)
		push |-> (int'(sp) + int'(step) <= stackDepth))
		else $error("call stack overflow");

	stackUnderflow: assert property (@(posedge clk) disable iff (!reset)
		pop |-> (sp >= step))
		else $error("pop from an empty call stack");

endmodule

`default_nettype wire

//--- verilog/controlUnit.sv
`timescale 1ns/1ns
`default_nettype none

module controlUnit #(
	parameter int memAddrWidth = 11
) (
	input logic clk,
	input logic reset,
	input logic run,
	input cpuPkg::word opcode,
	input cpuPkg::word par1,
	input cpuPkg::word par2,
	input cpuPkg::word readA,
	input cpuPkg::word readB,
	input cpuPkg::word bx,
	input cpuPkg::word dx,
	input cpuPkg::word dataOut,
	input cpuPkg::word logicResult,
	input cpuPkg::word arithResult,
	input logic carry,
	input logic zero,
	input logic overflow,
	input cpuPkg::word topWord,
	input cpuPkg::word nextWord,
	output cpuPkg::word fetchAddr,
	output cpuPkg::word dataAddr,
	output logic dataWrite,
	output cpuPkg::word dataIn,
	output cpuPkg::regIndex readSelA,
	output cpuPkg::regIndex readSelB,
	output logic writeEnA,
	output cpuPkg::regIndex writeSelA,
	output cpuPkg::word writeDataA,
	output logic writeEnB,
	output cpuPkg::regIndex writeSelB,
	output cpuPkg::word writeDataB,
	output cpuPkg::aluOp op,
	output cpuPkg::word aluA,
	output cpuPkg::word aluB,
	output logic carryIn,
	output logic aluStart,
	output logic push,
	output logic pop,
	output logic pair,
	output cpuPkg::word pushLow,
	output cpuPkg::word pushHigh,
	output logic outStrobe,
	output cpuPkg::word outAddr,
	output cpuPkg::word outData
);

	logic [memAddrWidth-1:0] pc;
	logic [memAddrWidth-1:0] pcNext;
	logic [memAddrWidth-1:0] pcPlus1;
	logic [memAddrWidth-1:0] pcPlus2;
	logic [memAddrWidth-1:0] pcPlus3;
	logic [memAddrWidth-1:0] jumpPc;
	cpuPkg::word bp;
	cpuPkg::word bpNext;
	cpuPkg::word jumpWord;
	logic cf, zf, of;
	logic cfNext, zfNext, ofNext;
	logic outFire;
	cpuPkg::execState state;
	cpuPkg::execState stateNext;

	assign pcPlus1 = pc + memAddrWidth'(1);
	assign pcPlus2 = pc + memAddrWidth'(2);
	assign pcPlus3 = pc + memAddrWidth'(3);
	assign jumpWord = par1 + bp; // JMP1, CALL and taken conditionals
	assign jumpPc = jumpWord[memAddrWidth-1:0];
	assign fetchAddr = cpuPkg::word'(pc);
	assign aluA = readA;
	assign aluB = readB;
	assign carryIn = cf;

	always_comb begin
		case (opcode)
			cpuPkg::opAdc: op = cpuPkg::aluAdc;
			cpuPkg::opSub, cpuPkg::opCmp: op = cpuPkg::aluSub;
			cpuPkg::opSuc: op = cpuPkg::aluSuc;
			cpuPkg::opAnd: op = cpuPkg::aluAnd;
			cpuPkg::opOr: op = cpuPkg::aluOr;
			cpuPkg::opXor: op = cpuPkg::aluXor;
			cpuPkg::opNeg: op = cpuPkg::aluNeg;
			cpuPkg::opNot: op = cpuPkg::aluNot;
			cpuPkg::opShl: op = cpuPkg::aluShl;
			cpuPkg::opShr: op = cpuPkg::aluShr;
			default: op = cpuPkg::aluAdd;
		endcase
	end

	always_comb begin
		readSelA = par1[3:2]; // dest
		readSelB = par1[1:0]; // src
		writeEnA = 1'b0;
		writeSelA = par1[3:2];
		writeDataA = logicResult;
		writeEnB = 1'b0;
		writeSelB = par1[1:0];
		writeDataB = dataOut;
		dataAddr = par1;
		dataWrite = 1'b0;
		dataIn = readB;
		aluStart = 1'b0;
		push = 1'b0;
		pop = 1'b0;
		pair = 1'b0;
		pushLow = readB;
		pushHigh = cpuPkg::word'(pcPlus2); // return address
		pcNext = pcPlus2;
		bpNext = bp;
		cfNext = cf;
		zfNext = zf;
		ofNext = of;
		outFire = 1'b0;
		stateNext = cpuPkg::stExec;
		if (!run) begin
			pcNext = '0; // held at the reset vector while loading
		end else begin
			case (opcode)
				cpuPkg::opScf: cfNext = par1[0];
				cpuPkg::opCff, cpuPkg::opCof, cpuPkg::opCzf: begin
					writeEnB = 1'b1;
					writeSelB = 2'd3;
					writeDataB = cpuPkg::word'(opcode == cpuPkg::opCff ? cf
						: (opcode == cpuPkg::opCof ? of : zf));
					pcNext = pcPlus1;
				end
				cpuPkg::opMov3: begin
					writeEnA = 1'b1;
					writeDataA = readB;
				end
				cpuPkg::opMov4: begin
					writeEnA = 1'b1;
					writeSelA = par1[1:0];
					writeDataA = par2;
					pcNext = pcPlus3;
				end
				cpuPkg::opMov5: begin
					readSelB = par2[1:0];
					dataWrite = 1'b1;
					pcNext = pcPlus3;
				end
				cpuPkg::opMov6: begin
					dataAddr = par2;
					writeEnB = 1'b1;
					pcNext = pcPlus3;
				end
				cpuPkg::opPush: push = 1'b1;
				cpuPkg::opPop: begin
					pop = 1'b1;
					writeEnB = 1'b1;
					writeDataB = topWord;
				end
				cpuPkg::opOut: begin
					outFire = 1'b1;
					pcNext = pcPlus1;
				end
				cpuPkg::opAdd, cpuPkg::opAdc, cpuPkg::opSub, cpuPkg::opSuc, cpuPkg::opCmp: begin
					if (state == cpuPkg::stExec) begin
						aluStart = 1'b1; // issue, pc holds
						pcNext = pc;
						stateNext = cpuPkg::stAluWait;
					end else begin
						writeEnA = (opcode != cpuPkg::opCmp);
						writeDataA = arithResult;
						cfNext = carry;
						zfNext = zero;
						ofNext = overflow;
					end
				end
				cpuPkg::opAnd, cpuPkg::opOr, cpuPkg::opXor: writeEnA = 1'b1;
				cpuPkg::opNeg, cpuPkg::opNot, cpuPkg::opShl, cpuPkg::opShr: begin
					readSelA = par1[1:0]; // single register in the low bits
					writeSelA = par1[1:0];
					writeEnA = 1'b1;
				end
				cpuPkg::opTest: zfNext = (readA == readB);
				cpuPkg::opJmp1: pcNext = jumpPc;
				cpuPkg::opJmp2: pcNext = par1[memAddrWidth-1:0];
				cpuPkg::opJc: pcNext = cf ? jumpPc : pcPlus2;
				cpuPkg::opJnc: pcNext = !cf ? jumpPc : pcPlus2;
				cpuPkg::opJz: pcNext = zf ? jumpPc : pcPlus2;
				cpuPkg::opJnz: pcNext = !zf ? jumpPc : pcPlus2;
				cpuPkg::opJo: pcNext = of ? jumpPc : pcPlus2;
				cpuPkg::opJno: pcNext = !of ? jumpPc : pcPlus2;
				cpuPkg::opCall: begin
					push = 1'b1;
					pair = 1'b1;
					pushLow = bp; // saved frame below the return address
					pcNext = jumpPc;
					bpNext = cpuPkg::word'(jumpPc);
				end
				cpuPkg::opRet: begin
					pop = 1'b1;
					pair = 1'b1;
					pcNext = topWord[memAddrWidth-1:0];
					bpNext = nextWord;
				end
				default: pcNext = pcPlus1; // NOP and unknown opcodes
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			pc <= '0;
			bp <= '0;
			cf <= 1'b0;
			zf <= 1'b0;
			of <= 1'b0;
			state <= cpuPkg::stExec;
			outStrobe <= 1'b0;
		end else begin
			pc <= pcNext;
			bp <= bpNext;
			cf <= cfNext;
			zf <= zfNext;
			of <= ofNext;
			state <= stateNext;
			outStrobe <= outFire; // one cycle pulse
		end
	end

	always_ff @(posedge clk) begin
		if (outFire) begin
			outAddr <= bx;
			outData <= dx;
		end
	end

	// collect always follows issue directly, so the wait state never repeats
	aluWaitOnce: assert property (@(posedge clk) disable iff (!reset)
		state == cpuPkg::stAluWait |=> state == cpuPkg::stExec)
		else $error("FSM stayed in stAluWait");

endmodule

`default_nettype wire

//--- verilog/cpuTop.sv
`timescale 1ns/1ns
`default_nettype none

module cpuTop #(
	parameter int memAddrWidth = 11, // 2048 words
	parameter int stackDepth = 64
) (
	input logic clk,
	input logic reset,
	input logic run,
	input logic loadEn,
	input cpuPkg::word loadAddr,
	input cpuPkg::word loadData,
	output logic outStrobe,
	output cpuPkg::word outAddr,
	output cpuPkg::word outData
);

	cpuPkg::word opcode, par1, par2, fetchAddr;
	cpuPkg::word dataAddr, dataIn, dataOut;
	logic dataWrite;
	cpuPkg::regIndex readSelA, readSelB, writeSelA, writeSelB;
	cpuPkg::word readA, readB, writeDataA, writeDataB, bx, dx;
	logic writeEnA, writeEnB;
	cpuPkg::aluOp op;
	cpuPkg::word aluA, aluB, logicResult, arithResult;
	logic carryIn, aluStart, carry, zero, overflow;
	logic push, pop, pair;
	cpuPkg::word pushLow, pushHigh, topWord, nextWord;

	programMemory #(.memAddrWidth(memAddrWidth)) i_programMemory (.*);

	registerFile i_registerFile (.*);

	alu i_alu (
		.*,
		.a(aluA),
		.b(aluB)
	);

	callStack #(.stackDepth(stackDepth)) i_callStack (.*);

	controlUnit #(.memAddrWidth(memAddrWidth)) i_controlUnit (.*);

endmodule

`default_nettype wire

//--- bench/cpuPrograms.svh
`ifndef CPU_PROGRAMS_SVH
`define CPU_PROGRAMS_SVH

localparam int numTests = 12;
localparam int progLen = 20;
localparam int randomTest = 11; // immediates at words 2 and 5 filled at run time

string testName [numTests] = '{"moves", "carryFlags", "borrow", "overflow", "andXor",
	"shiftNot", "orTest", "memory", "stack", "jumps", "callRet", "randomAdd"};

// one program per test, loaded from address 0, unused words are NOP
cpuPkg::word programs [numTests][progLen] = '{
	// MOV4 bx and ax, MOV3 dx<-ax, OUT, MOV4 cx, MOV3 dx<-cx, OUT
	'{'h0008, 'h0001, 'h0010, 'h0008, 'h0000, 'h1234, 'h0007, 'h000C, 'h000A, 'h0008,
		'h0002, 'hBEEF, 'h0007, 'h000E, 'h000A, 'h0031, 'h000F, 'h0000, 'h0000, 'h0000},
	// FFFF + 1, then CFF, CZF, COF and ADC dx,cx
	'{'h0008, 'h0000, 'hFFFF, 'h0008, 'h0002, 'h0001, 'h000C, 'h0002, 'h0002, 'h000A,
		'h0004, 'h000A, 'h0003, 'h000A, 'h000D, 'h000E, 'h000A, 'h0031, 'h0011, 'h0000},
	// 3 - 5, SUC with the borrow, CMP cx,dx keeps cx
	'{'h0008, 'h0003, 'h0003, 'h0008, 'h0002, 'h0005, 'h000E, 'h000E, 'h000F, 'h000E,
		'h000A, 'h0014, 'h000B, 'h0002, 'h000A, 'h0007, 'h000E, 'h000A, 'h0031, 'h0012},
	// 7FFF + 1, then COF
	'{'h0008, 'h0003, 'h7FFF, 'h0008, 'h0002, 'h0001, 'h000C, 'h000E, 'h000A, 'h0003,
		'h000A, 'h0031, 'h000B, 'h0000, 'h0000, 'h0000, 'h0000, 'h0000, 'h0000, 'h0000},
	// SCF 1, AND and XOR dx,cx, cf must survive
	'{'h0001, 'h0001, 'h0008, 'h0003, 'h00F0, 'h0008, 'h0002, 'h0F3C, 'h0015, 'h000E,
		'h000A, 'h001B, 'h000E, 'h000A, 'h0002, 'h000A, 'h0031, 'h0010, 'h0000, 'h0000},
	// SHL, NEG, SHR on dx, then NOT twice
	'{'h0008, 'h0003, 'h8001, 'h0019, 'h0003, 'h0016, 'h0003, 'h001A, 'h0003, 'h000A,
		'h0017, 'h0003, 'h000A, 'h0017, 'h0003, 'h000A, 'h0031, 'h0010, 'h0000, 'h0000},
	// OR dx,ax, TEST unequal then equal, zf via CZF
	'{'h0008, 'h0003, 'h1200, 'h0008, 'h0000, 'h0034, 'h0018, 'h000C, 'h000A, 'h001C,
		'h000C, 'h0004, 'h000A, 'h001C, 'h000D, 'h0004, 'h000A, 'h0031, 'h0011, 'h0000},
	// MOV5 to 0x100, MOV6 back into dx
	'{'h0008, 'h0000, 'hABCD, 'h002A, 'h0100, 'h0000, 'h002B, 'h0003, 'h0100, 'h0008,
		'h0001, 'h0100, 'h000A, 'h0031, 'h000D, 'h0000, 'h0000, 'h0000, 'h0000, 'h0000},
	// PUSH ax, PUSH bx, POP cx, POP dx
	'{'h0008, 'h0000, 'h1111, 'h0008, 'h0001, 'h2222, 'h000B, 'h0000, 'h000B, 'h0001,
		'h0009, 'h0002, 'h0009, 'h0003, 'h000A, 'h0007, 'h000E, 'h000A, 'h0031, 'h0012},
	// zf=1 cf=0: JNZ falls through, JZ skips an OUT, JC falls through
	'{'h0008, 'h0003, 'h00AA, 'h000E, 'h0000, 'h0024, 'h0012, 'h000A, 'h0023, 'h000D,
		'h000A, 'h0031, 'h000B, 'h0016, 'h0003, 'h0021, 'h0012, 'h000A, 'h0031, 'h0012},
	// CALL 13, subroutine skips a NEG with JMP1 6, RET, then JMP1 10 with bp back at 0
	'{'h0008, 'h0003, 'h0011, 'h001E, 'h000D, 'h000A, 'h0020, 'h000A, 'h0016, 'h0003,
		'h000A, 'h0031, 'h000B, 'h0016, 'h0003, 'h0020, 'h0006, 'h0016, 'h0003, 'h001F},
	// ADD dx,cx on random operands, then CFF
	'{'h0008, 'h0003, 'h0000, 'h0008, 'h0002, 'h0000, 'h000C, 'h000E, 'h000A, 'h0002,
		'h000A, 'h0031, 'h000B, 'h0000, 'h0000, 'h0000, 'h0000, 'h0000, 'h0000, 'h0000}
};

int expCount [numTests] = '{2, 4, 3, 2, 3, 3, 3, 1, 2, 2, 2, 2};

// {outAddr, outData} of each expected OUT, in order
logic [31:0] expOut [numTests][4] = '{
	'{'h00101234, 'h0010BEEF, 0, 0},
	'{'h00000001, 'h00000001, 'h00000000, 'h00000002},
	'{'h0000FFF8, 'h00000001, 'h00000005, 0},
	'{'h00008000, 'h00000001, 0, 0},
	'{'h00000030, 'h00000F0C, 'h00000001, 0},
	'{'h00007FFE, 'h00000000, 'h00000001, 0},
	'{'h00001234, 'h00000000, 'h00000001, 0},
	'{'h0100ABCD, 0, 0, 0},
	'{'h22221111, 'h22222222, 0, 0},
	'{'h000000AA, 'h0000FF55, 0, 0},
	'{'h0000FFEE, 'h0000FFEE, 0, 0},
	'{0, 0, 0, 0}
};

`endif

//--- bench/cpuTb.sv
`timescale 1ns/1ns
`default_nettype none

module cpuTb;

	`include "cpuPrograms.svh"

	localparam int waitLimit = 200; // cycles allowed per OUT

	logic clk;
	logic reset;
	logic run;
	logic loadEn;
	cpuPkg::word loadAddr;
	cpuPkg::word loadData;
	logic outStrobe;
	cpuPkg::word outAddr;
	cpuPkg::word outData;

	integer seed;
	int testErrors;
	int passCount;
	int failCount;

	cpuTop i_cpuTop (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic applyReset();
		@(negedge clk);
		reset = 1'b0;
		run = 1'b0;
		loadEn = 1'b0;
		repeat (3) @(negedge clk);
		reset = 1'b1;
	endtask

	task automatic loadProgram(input int t);
		for (int i = 0; i < progLen; i++) begin
			loadEn = 1'b1;
			loadAddr = cpuPkg::word'(i);
			loadData = programs[t][i];
			@(negedge clk); // written at the rising edge before
		end
		loadEn = 1'b0;
	endtask

	task automatic collectOutput(output logic seen, output cpuPkg::word addr,
		output cpuPkg::word data);
		int cycles;
		seen = 1'b0;
		addr = '0;
		data = '0;
		cycles = 0;
		while (!seen && cycles < waitLimit) begin
			@(negedge clk); // strobe is stable mid cycle
			cycles++;
			if (outStrobe) begin
				seen = 1'b1;
				addr = outAddr;
				data = outData;
			end
		end
	endtask

	initial begin
		logic seen;
		cpuPkg::word gotAddr;
		cpuPkg::word gotData;
		cpuPkg::word opA;
		cpuPkg::word opB;
		int total;
		seed = 5;
		reset = 1'b0;
		run = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		passCount = 0;
		failCount = 0;
		for (int t = 0; t < numTests; t++) begin
			testErrors = 0;
			if (t == randomTest) begin
				opA = cpuPkg::word'($random(seed));
				opB = cpuPkg::word'($random(seed));
				total = int'(opA) + int'(opB); // plain integer sum
				programs[t][2] = opA;
				programs[t][5] = opB;
				expOut[t][0] = {16'h0000, cpuPkg::word'(total % 65536)};
				expOut[t][1] = (total >= 65536) ? 32'd1 : 32'd0; // carry out
			end
			applyReset();
			loadProgram(t);
			run = 1'b1;
			for (int k = 0; k < expCount[t]; k++) begin
				collectOutput(seen, gotAddr, gotData);
				if (!seen) begin
					$display("test %s: output %0d missing, no outStrobe within %0d cycles",
						testName[t], k, waitLimit);
					testErrors++;
					break;
				end
				assert (gotAddr == expOut[t][k][31:16]) else begin
					$display("error: test %s output %0d outAddr expected %h got %h",
						testName[t], k, expOut[t][k][31:16], gotAddr);
					testErrors++;
				end
				assert (gotData == expOut[t][k][15:0]) else begin
					$display("error: test %s output %0d outData expected %h got %h",
						testName[t], k, expOut[t][k][15:0], gotData);
					testErrors++;
				end
			end
			run = 1'b0;
			if (testErrors == 0) begin
				$display("test %s: pass", testName[t]);
				passCount++;
			end else begin
				$display("test %s: fail with %0d errors", testName[t], testErrors);
				failCount++;
			end
		end
		$display("%0d tests passed, %0d failed", passCount, failCount);
		if (failCount == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+bench
verilog/cpuPkg.sv
verilog/programMemory.sv
verilog/registerFile.sv
verilog/alu.sv
verilog/callStack.sv
verilog/controlUnit.sv
verilog/cpuTop.sv
bench/cpuTb.sv

//--- run.sh
#!/bin/sh
# build and run the cpuTb simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module cpuTb

output=$(./obj_dir/VcpuTb)
echo "$output"
echo "$output" | grep -q "All checks passed"
